//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_core_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [31:0]      inst,
  output logic [pc_w-1:0]  pc,
  output logic             halt,
  output logic             commit_valid,
  output logic [pc_w-1:0]  commit_pc,
  output logic [4:0]       commit_rd,
  output logic [xlen-1:0]  commit_data
);

  dec_t             dec;
  exe_t             exe;
  logic [4:0]       rs1_addr;
  logic [xlen-1:0]  rs1_data;
  logic             wr_en;
  logic [4:0]       wr_addr;
  logic [xlen-1:0]  wr_data;

  rv_decode rv_decode_inst (
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs1_addr (rs1_addr),
    .dec      (dec)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_execute rv_execute_inst (
    .pc  (pc),
    .dec (dec),
    .exe (exe)
  );

  // pc, halt and commit live in the result stage
  rv_result rv_result_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .exe          (exe),
    .pc           (pc),
    .halt         (halt),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/100ps

module rv_decode
  import rv_pkg::*;
(
  input  logic [31:0]      inst,
  input  logic [pc_w-1:0]  pc,
  input  logic [xlen-1:0]  rs1_data,
  output logic [4:0]       rs1_addr,
  output dec_t             dec
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [xlen-1:0]  imm_i;
  logic [xlen-1:0]  imm_u;
  logic [pc_w-1:0]  imm_j;
  logic [xlen-1:0]  pc_ext;
  inst_kind_e       kind;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // immediates, all sign extended from inst[31]
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(pc_w-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign pc_ext = {{(xlen-pc_w){1'b0}}, pc};

  assign rs1_addr = inst[19:15];

  // instruction class
  always_comb begin
    kind = k_none;
    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin
          kind = k_addi;
        end
      end
      op_lui:   kind = k_lui;
      op_auipc: kind = k_auipc;
      op_jal:   kind = k_jal;
      op_system: begin
        // only ebreak is handled in the system space
        if (funct3 == 3'b000 && inst[31:20] == 12'h001) begin
          kind = k_ebreak;
        end
      end
      default:  kind = k_none;
    endcase
  end

  // operand select
  always_comb begin
    dec          = '0;
    dec.kind     = kind;
    dec.imm_j    = imm_j;
    dec.rs1_addr = inst[19:15];
    dec.rd_addr  = inst[11:7];
    case (kind)
      k_addi: begin
        dec.op1   = rs1_data;
        dec.op2   = imm_i;
        dec.rd_en = 1'b1;
      end
      k_lui: begin
        dec.op1   = '0;
        dec.op2   = imm_u;
        dec.rd_en = 1'b1;
      end
      k_auipc: begin
        dec.op1   = pc_ext;
        dec.op2   = imm_u;
        dec.rd_en = 1'b1;
      end
      k_jal: begin
        // link value pc + 4
        dec.op1   = pc_ext;
        dec.op2   = xlen'(4);
        dec.rd_en = 1'b1;
      end
      default: begin
        dec.rd_en = 1'b0;
      end
    endcase
  end

  always_comb begin
    assert (kind inside {k_none, k_addi, k_lui, k_auipc, k_jal, k_ebreak})
      else $error("decode produced an undefined instruction kind");
  end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/100ps

module rv_execute
  import rv_pkg::*;
(
  input  logic [pc_w-1:0]  pc,
  input  dec_t             dec,
  output exe_t             exe
);

  logic [pc_w-1:0] seq_pc;
  logic [pc_w-1:0] jump_pc;

  assign seq_pc  = pc + pc_w'(4);
  assign jump_pc = pc + dec.imm_j;

  // operand adder serves addi, lui, auipc and the jal link
  assign exe.rd_data = dec.op1 + dec.op2;
  assign exe.rd_addr = dec.rd_addr;
  assign exe.rd_en   = dec.rd_en;

  assign exe.halt_req = (dec.kind == k_ebreak);

  always_comb begin
    case (dec.kind)
      k_jal:    exe.next_pc = jump_pc;
      // ebreak parks on its own pc
      k_ebreak: exe.next_pc = pc;
      default:  exe.next_pc = seq_pc;
    endcase
  end

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

  // data and address widths
  localparam int xlen = 64;
  localparam int pc_w = 32;

  localparam logic [pc_w-1:0] reset_pc = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // recognized instruction classes
  typedef enum logic [2:0] {
    k_none,
    k_addi,
    k_lui,
    k_auipc,
    k_jal,
    k_ebreak
  } inst_kind_e;

  // decode to execute and result
  typedef struct packed {
    inst_kind_e        kind;
    logic [xlen-1:0]   op1;
    logic [xlen-1:0]   op2;
    logic [pc_w-1:0]   imm_j;
    logic [4:0]        rs1_addr;
    logic [4:0]        rd_addr;
    logic              rd_en;
  } dec_t;

  // execute to result
  typedef struct packed {
    logic [xlen-1:0]   rd_data;
    logic [pc_w-1:0]   next_pc;
    logic [4:0]        rd_addr;
    logic              rd_en;
    logic              halt_req;
  } exe_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       rs1_addr,
  output logic [xlen-1:0]  rs1_data,
  input  logic             wr_en,
  input  logic [4:0]       wr_addr,
  input  logic [xlen-1:0]  wr_data
);

  logic [xlen-1:0] regs [32];

  // x0 reads zero since the write-back never targets it
  assign rs1_data = regs[rs1_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // a stray x0 write would leak through any later read path
  assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
    else $error("register x0 holds a nonzero value");

endmodule

//--- hdl/rv_result.sv
`timescale 1ns/100ps

module rv_result
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  exe_t             exe,
  output logic [pc_w-1:0]  pc,
  output logic             halt,
  output logic             wr_en,
  output logic [4:0]       wr_addr,
  output logic [xlen-1:0]  wr_data,
  output logic             commit_valid,
  output logic [pc_w-1:0]  commit_pc,
  output logic [4:0]       commit_rd,
  output logic [xlen-1:0]  commit_data
);

  // write-back only while running and for a real rd
  assign wr_en   = exe.rd_en && !halt && (exe.rd_addr != 5'd0);
  assign wr_addr = exe.rd_addr;
  assign wr_data = exe.rd_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc           <= reset_pc;
      halt         <= 1'b0;
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= wr_en;
      if (!halt) begin
        pc   <= exe.next_pc;
        halt <= exe.halt_req;
      end
    end
  end

  // commit record of the retiring write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      commit_pc   <= pc;
      commit_rd   <= exe.rd_addr;
      commit_data <= exe.rd_data;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) $past(halt) |-> !commit_valid)
    else $error("commit reported after the core halted");

endmodule

//--- project.f
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb
  import rv_pkg::*;
();

  localparam int num_insts    = 2000;
  localparam int edge_polls   = 20;
  localparam int halt_timeout = 10;
  localparam int quiet_cycles = 20;

  // one expected commit record
  typedef struct packed {
    logic             valid;
    logic [pc_w-1:0]  pc;
    logic [4:0]       rd;
    logic [xlen-1:0]  data;
  } commit_t;

  logic             clk;
  logic             rst_n;
  logic [31:0]      inst;
  logic [pc_w-1:0]  pc;
  logic             halt;
  logic             commit_valid;
  logic [pc_w-1:0]  commit_pc;
  logic [4:0]       commit_rd;
  logic [xlen-1:0]  commit_data;

  int cycle_cnt = 0;

  // architectural model
  logic [xlen-1:0]  model_regs [32];
  logic [pc_w-1:0]  model_pc;
  commit_t          exp_commit;

  rv_core rv_core_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .pc           (pc),
    .halt         (halt),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // lands 1 ns after the next rising edge
  task automatic next_cycle();
    int start;
    int polls;
    start = cycle_cnt;
    polls = 0;
    while (cycle_cnt == start && polls < edge_polls) begin
      #0.5;
      polls++;
    end
    if (cycle_cnt == start) begin
      stop_with_failure("no rising clock edge seen, the clock has stopped");
    end
    #0.5;
  endtask

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [4:0] rd, input logic [6:0] opcode);
    return {imm, rs1, 3'b000, rd, opcode};
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  // J format scrambles the offset bits
  function automatic logic [31:0] jtype_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic logic [6:0] unknown_opcode(input logic [1:0] sel);
    case (sel)
      2'd0:    return 7'b0000011;  // load
      2'd1:    return 7'b0100011;  // store
      2'd2:    return 7'b1100011;  // branch
      default: return 7'b1100111;  // jalr
    endcase
  endfunction

  // draws one instruction, drives it and retires it in the model
  task automatic issue_random_instruction();
    int               choice;
    int               jal_step;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [11:0]      imm12;
    logic [19:0]      imm20;
    logic [20:0]      off21;
    logic [xlen-1:0]  value;
    logic             writes;
    logic [pc_w-1:0]  next_pc;
    choice   = int'($urandom_range(0, 99));
    rd       = 5'($urandom_range(0, 31));
    rs1      = 5'($urandom_range(0, 31));
    imm12    = 12'($urandom());
    imm20    = 20'($urandom());
    jal_step = int'($urandom_range(0, 63)) - 32;
    off21    = 21'(jal_step * 2);
    writes   = 1'b1;
    next_pc  = model_pc + 32'd4;
    if (choice < 40) begin
      // x0 as a source reads zero in the model too
      inst  = itype_word(imm12, rs1, rd, op_imm);
      value = model_regs[rs1] + {{(xlen-12){imm12[11]}}, imm12};
    end else if (choice < 55) begin
      inst  = utype_word(imm20, rd, op_lui);
      value = {{(xlen-32){imm20[19]}}, imm20, 12'b0};
    end else if (choice < 70) begin
      inst  = utype_word(imm20, rd, op_auipc);
      value = {{(xlen-pc_w){1'b0}}, model_pc} + {{(xlen-32){imm20[19]}}, imm20, 12'b0};
    end else if (choice < 88) begin
      inst    = jtype_word(off21, rd);
      value   = {{(xlen-pc_w){1'b0}}, model_pc} + xlen'(4);
      next_pc = model_pc + {{(pc_w-21){off21[20]}}, off21};
    end else begin
      inst   = {25'($urandom()), unknown_opcode(2'($urandom_range(0, 3)))};
      value  = '0;
      writes = 1'b0;
    end
    exp_commit.valid = writes && (rd != 5'd0);
    exp_commit.pc    = model_pc;
    exp_commit.rd    = rd;
    exp_commit.data  = value;
    if (exp_commit.valid) begin
      model_regs[rd] = value;
    end
    model_pc = next_pc;
  endtask

  task automatic check_outputs(input string tag, input logic exp_halt);
    check_value({tag, " pc"}, 64'(model_pc), 64'(pc));
    check_value({tag, " halt"}, 64'(exp_halt), 64'(halt));
    check_value({tag, " commit_valid"}, 64'(exp_commit.valid), 64'(commit_valid));
    if (exp_commit.valid) begin
      check_value({tag, " commit_pc"}, 64'(exp_commit.pc), 64'(commit_pc));
      check_value({tag, " commit_rd"}, 64'(exp_commit.rd), 64'(commit_rd));
      check_value({tag, " commit_data"}, exp_commit.data, commit_data);
    end
  endtask

  initial begin
    int n;
    int waited;
    void'($urandom(32'had10817e));
    rst_n      = 1'b0;
    inst       = '0;
    model_pc   = reset_pc;
    exp_commit = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end

    repeat (5) next_cycle();
    rst_n = 1'b1;
    check_outputs("reset", 1'b0);

    for (n = 0; n < num_insts; n++) begin
      issue_random_instruction();
      next_cycle();
      check_outputs($sformatf("inst %0d", n), 1'b0);
    end

    // ebreak parks the core on its own pc
    inst       = itype_word(12'h001, 5'd0, 5'd0, op_system);
    exp_commit = '0;
    waited     = 0;
    while (!halt && waited < halt_timeout) begin
      next_cycle();
      waited++;
    end
    if (!halt) begin
      stop_with_failure("halt did not rise after ebreak within the timeout");
    end
    check_outputs("ebreak", 1'b1);

    // writes offered while halted must be dropped
    for (n = 0; n < quiet_cycles; n++) begin
      inst = itype_word(12'($urandom()), 5'($urandom_range(0, 31)),
                        5'($urandom_range(1, 31)), op_imm);
      next_cycle();
      check_outputs($sformatf("halted %0d", n), 1'b1);
    end

    $display("Regression passed");
    $finish;
  end

endmodule
